// ==== common/madam_pkg.sv ====
// shared definitions for the madam register file, line-flag receiver and matrix engine.
// every user refers to them by scoped name, madam_pkg::name.

package madam_pkg;

	// bus and datapath widths.
	localparam int DATA_W      = 32;          // cpu data word.
	localparam int REG_OFS_W   = 16;          // decoded low half of cpu_addr.
	localparam int HCOUNT_W    = 12;          // horizontal cycle counter.
	localparam int LINE_FLAG_W = 7;           // pcsc bits 1 to 7.
	localparam int MTX_IDX_W   = 5;           // word index inside the matrix window.
	localparam int FRAC_BITS   = 16;          // 16.16 fixed point.
	localparam int ACC_W       = 2 * DATA_W;  // full product and accumulator width.

	// matrix geometry.
	localparam int MTX_DIM     = 4;           // rows and columns of the full matrix.
	localparam int MTX_M_WORDS = MTX_DIM * MTX_DIM;
	localparam int MTX_WORDS   = 32;          // words in the whole window.

	// register offsets within the madam block.
	localparam logic [REG_OFS_W-1:0] REG_MSYSBITS  = 16'h0004;  // memory config, read only.
	localparam logic [REG_OFS_W-1:0] REG_MCTL      = 16'h0008;  // dma enables.
	localparam logic [REG_OFS_W-1:0] REG_MSB_CHECK = 16'h002C;  // msb finder.
	localparam logic [REG_OFS_W-1:0] REG_LINE_STAT = 16'h0030;  // hcount and line flags.
	localparam logic [REG_OFS_W-1:0] REG_REGCTL0   = 16'h0130;  // frame buffer modulo.
	localparam logic [REG_OFS_W-1:0] REG_REGCTL1   = 16'h0134;  // x/y clip.
	localparam logic [REG_OFS_W-1:0] REG_REGCTL2   = 16'h0138;  // read base address.
	localparam logic [REG_OFS_W-1:0] REG_REGCTL3   = 16'h013C;  // write base address.
	localparam logic [REG_OFS_W-1:0] REG_VDL_ADDR  = 16'h0580;  // vdl list pointer.
	localparam logic [REG_OFS_W-1:0] MTX_BASE      = 16'h0600;  // start of matrix window.
	localparam logic [REG_OFS_W-1:0] MTX_END       = 16'h0680;  // first offset past the window.
	localparam logic [REG_OFS_W-1:0] MTX_CMD       = 16'h07FC;  // matrix command word.

	// fixed read values.
	localparam logic [DATA_W-1:0] MSYSBITS_VALUE = 32'h0000_0029;  // 2MB dram, 1MB vram.
	localparam logic [DATA_W-1:0] BAD_ACCESS     = 32'hBADA_CCE5;  // unmapped offsets.
	localparam logic [DATA_W-1:0] NO_MSB         = '1;             // msb finder, no bit set.

	// line status word layout.
	localparam int LSTAT_HCOUNT_LSB = 16;  // hcount sits in bits 27:16.

	// matrix window layout, by word index.
	// matrix words are 0 to 15, row-major.
	localparam logic [MTX_IDX_W-1:0] MTX_V_BASE   = 5'd16;  // vector words 16 to 19.
	localparam logic [MTX_IDX_W-1:0] MTX_REZ_BASE = 5'd24;  // result words 24 to 27.

	// matrix commands, taken from the low 2 bits of the command write.
	typedef enum logic [1:0] {
		MTX_NOP  = 2'd0,  // publish pending results only.
		MTX_MUL4 = 2'd1,  // 4x4 matrix times vector.
		MTX_MUL3 = 2'd2   // 3x3 matrix times vector.
	} mtx_cmd_e;

endpackage

// ==== hdl/line_flags.sv ====
// line-flag receiver for the pcsc serial line.
// a rising edge on pcsc marks a new line, the following 7 bits are the video
// flags, published together once the last one is in. also runs hcount.

`timescale 1ns/1ps

module line_flags (
	input  logic                              clk_25m,
	input  logic                              reset_n,
	input  logic                              pcsc,
	output logic [madam_pkg::LINE_FLAG_W-1:0] flags,   // vz, v#, f#, fc, vr, vd, vl.
	output logic [madam_pkg::HCOUNT_W-1:0]    hcount   // half-rate cycles since line start.
);

	logic                              pcsc_q;    // first sample.
	logic                              pcsc_qq;   // previous sample, for edge detect.
	logic                              pcsc_rise;
	logic [2:0]                        bit_idx;   // 0 when idle, 1 to 7 while receiving.
	logic [madam_pkg::LINE_FLAG_W-2:0] shift_q;   // flags 1 to 6 while they arrive.
	logic                              hphase;    // hcount steps on every other cycle.

	assign pcsc_rise = pcsc_q && !pcsc_qq;

	always_ff @(posedge clk_25m or negedge reset_n) begin
		if (!reset_n) begin
			pcsc_q  <= 1'b0;
			pcsc_qq <= 1'b0;
			bit_idx <= '0;
			shift_q <= '0;
			flags   <= '0;
			hcount  <= '0;
			hphase  <= 1'b0;
		end else begin
			pcsc_q  <= pcsc;
			pcsc_qq <= pcsc_q;

			// only an idle receiver arms, so flag bits toggling pcsc can't restart it.
			if (pcsc_rise && (bit_idx == 3'd0)) begin
				bit_idx <= 3'd1;
				hcount  <= '0;
				hphase  <= 1'b0;
			end else begin
				hphase <= !hphase;
				if (hphase)
					hcount <= hcount + 1'b1;  // wraps.
			end

			if (bit_idx != 3'd0) begin
				shift_q <= {pcsc_q, shift_q[madam_pkg::LINE_FLAG_W-2:1]};  // lsb first.
				bit_idx <= bit_idx + 3'd1;  // stops when it wraps to zero.
				if (bit_idx == 3'd7)
					flags <= {pcsc_q, shift_q};  // whole set at once.
			end
		end
	end

endmodule

// ==== matrix/matrix_engine.sv ====
// madam matrix engine.
// holds the 4x4 matrix, the vector and the results of the 32-word window.
// a command first publishes the pending results, then mul4 or mul3 runs one
// signed multiply per cycle into a 64-bit accumulator while mtx_busy is high.

`timescale 1ns/1ps

module matrix_engine (
	input  logic                            clk_25m,
	input  logic                            reset_n,

	input  logic                            mtx_wr,      // window write, ignored while busy.
	input  logic [madam_pkg::MTX_IDX_W-1:0] mtx_idx,
	input  logic [madam_pkg::DATA_W-1:0]    mtx_wdata,
	input  logic                            mtx_cmd_wr,  // command write, ignored while busy.
	input  madam_pkg::mtx_cmd_e             mtx_cmd,

	output logic [madam_pkg::DATA_W-1:0]    mtx_rdata,   // word at mtx_idx, combinational.
	output logic                            mtx_busy
);

	localparam int VEC_TOP = madam_pkg::MTX_V_BASE + madam_pkg::MTX_DIM;
	localparam int REZ_TOP = madam_pkg::MTX_REZ_BASE + madam_pkg::MTX_DIM;

	logic [madam_pkg::DATA_W-1:0] m_q      [madam_pkg::MTX_M_WORDS];  // row-major.
	logic [madam_pkg::DATA_W-1:0] v_q      [madam_pkg::MTX_DIM];
	logic [madam_pkg::DATA_W-1:0] rez      [madam_pkg::MTX_DIM];      // visible results.
	logic [madam_pkg::DATA_W-1:0] rez_pend [madam_pkg::MTX_DIM];      // from the last multiply.

	logic                            cmd_accept;
	logic                            mul3;      // 3x3 run in progress.
	logic [1:0]                      row;
	logic [1:0]                      col;
	logic [1:0]                      last_idx;  // 2 for 3x3, 3 for 4x4.
	logic signed [madam_pkg::ACC_W-1:0] product;
	logic signed [madam_pkg::ACC_W-1:0] acc_q;
	logic signed [madam_pkg::ACC_W-1:0] acc_next;
	logic signed [madam_pkg::ACC_W-1:0] acc_shift;

	assign cmd_accept = mtx_cmd_wr && !mtx_busy;
	assign last_idx   = mul3 ? 2'd2 : 2'd3;

	// one multiplier, the row and column pick the operands.
	assign product   = $signed(m_q[{row, col}]) * $signed(v_q[col]);
	assign acc_next  = ((col == 2'd0) ? '0 : acc_q) + product;  // first column starts fresh.
	assign acc_shift = acc_next >>> madam_pkg::FRAC_BITS;         // back to 16.16.

	// matrix and vector storage, frozen during a run.
	always_ff @(posedge clk_25m or negedge reset_n) begin
		if (!reset_n) begin
			for (int i = 0; i < madam_pkg::MTX_M_WORDS; i++)
				m_q[i] <= '0;
			for (int i = 0; i < madam_pkg::MTX_DIM; i++)
				v_q[i] <= '0;
		end else if (mtx_wr && !mtx_busy) begin
			if (mtx_idx < madam_pkg::MTX_V_BASE)
				m_q[mtx_idx[3:0]] <= mtx_wdata;
			else if (mtx_idx < VEC_TOP)
				v_q[mtx_idx[1:0]] <= mtx_wdata;
			// result words and the gaps are not writable.
		end
	end

	// running sum of the current row.
	always_ff @(posedge clk_25m) begin
		if (mtx_busy)
			acc_q <= acc_next;
	end

	// command accept and row/column sequencer.
	always_ff @(posedge clk_25m or negedge reset_n) begin
		if (!reset_n) begin
			mtx_busy <= 1'b0;
			mul3     <= 1'b0;
			row      <= '0;
			col      <= '0;
			for (int i = 0; i < madam_pkg::MTX_DIM; i++) begin
				rez[i]      <= '0;
				rez_pend[i] <= '0;
			end
		end else if (cmd_accept) begin
			// every command publishes what the previous one computed.
			for (int i = 0; i < madam_pkg::MTX_DIM; i++)
				rez[i] <= rez_pend[i];
			row <= '0;
			col <= '0;
			case (mtx_cmd)
				madam_pkg::MTX_MUL4: begin
					mtx_busy <= 1'b1;  // 16 cycles.
					mul3     <= 1'b0;
				end
				madam_pkg::MTX_MUL3: begin
					mtx_busy <= 1'b1;  // 9 cycles, pending result 3 untouched.
					mul3     <= 1'b1;
				end
				default: ;  // nop and unknown codes only publish.
			endcase
		end else if (mtx_busy) begin
			if (col == last_idx) begin
				rez_pend[row] <= acc_shift[madam_pkg::DATA_W-1:0];  // low 32 bits.
				col <= '0;
				if (row == last_idx)
					mtx_busy <= 1'b0;  // last row done.
				else
					row <= row + 2'd1;
			end else begin
				col <= col + 2'd1;
			end
		end
	end

	// read back by word index.
	always_comb begin
		mtx_rdata = '0;  // unused indices.
		if (mtx_idx < madam_pkg::MTX_V_BASE)
			mtx_rdata = m_q[mtx_idx[3:0]];
		else if (mtx_idx < VEC_TOP)
			mtx_rdata = v_q[mtx_idx[1:0]];
		else if ((mtx_idx >= madam_pkg::MTX_REZ_BASE) && (mtx_idx < REZ_TOP))
			mtx_rdata = rez[mtx_idx[1:0]];
	end

endmodule

// ==== hdl/madam_regs.sv ====
// madam register file.
// decodes the 16-bit offset of cpu_addr, holds the plain registers and the
// msb finder, forwards matrix window and command accesses to the matrix engine
// and builds the combinational read data.

`timescale 1ns/1ps

module madam_regs (
	input  logic                               clk_25m,
	input  logic                               reset_n,

	input  logic [31:0]                        cpu_addr,
	input  logic [31:0]                        cpu_din,
	input  logic                               cpu_wr,
	output logic [31:0]                        cpu_dout,

	input  logic [madam_pkg::LINE_FLAG_W-1:0]  flags,   // from the line-flag receiver.
	input  logic [madam_pkg::HCOUNT_W-1:0]     hcount,

	output logic                               mtx_wr,      // one cycle per window write.
	output logic [madam_pkg::MTX_IDX_W-1:0]    mtx_idx,     // word index, for reads too.
	output logic [madam_pkg::DATA_W-1:0]       mtx_wdata,
	output logic                               mtx_cmd_wr,  // one cycle per command write.
	output madam_pkg::mtx_cmd_e                mtx_cmd,
	input  logic [madam_pkg::DATA_W-1:0]       mtx_rdata,
	input  logic                               mtx_busy
);

	logic [madam_pkg::REG_OFS_W-1:0] ofs;  // decoded register offset.
	logic                            mtx_hit;

	logic [madam_pkg::DATA_W-1:0] mctl;       // dma channel enables.
	logic [madam_pkg::DATA_W-1:0] regctl0;    // modulo for source and destination buffers.
	logic [madam_pkg::DATA_W-1:0] regctl1;    // x/y clip.
	logic [madam_pkg::DATA_W-1:0] regctl2;    // source buffer base.
	logic [madam_pkg::DATA_W-1:0] regctl3;    // destination buffer base.
	logic [madam_pkg::DATA_W-1:0] vdl_addr;
	logic [madam_pkg::DATA_W-1:0] msb_check;  // raw value, the finder reads from it.
	logic [madam_pkg::DATA_W-1:0] msb_idx;    // index of its highest set bit.
	logic [madam_pkg::DATA_W-1:0] line_stat;

	assign ofs = cpu_addr[madam_pkg::REG_OFS_W-1:0];

	// window is 0x600 to 0x67c, word aligned.
	assign mtx_hit = (ofs >= madam_pkg::MTX_BASE) && (ofs < madam_pkg::MTX_END) &&
		(ofs[1:0] == 2'b00);

	// base is 128-byte aligned so the index is just the word address bits.
	assign mtx_idx    = ofs[madam_pkg::MTX_IDX_W+1:2];
	assign mtx_wdata  = cpu_din;
	assign mtx_wr     = cpu_wr && mtx_hit;
	assign mtx_cmd_wr = cpu_wr && (ofs == madam_pkg::MTX_CMD);
	assign mtx_cmd    = madam_pkg::mtx_cmd_e'(cpu_din[1:0]);  // code 3 passes through as a nop.

	// plain register writes.
	always_ff @(posedge clk_25m or negedge reset_n) begin
		if (!reset_n) begin
			mctl      <= '0;
			regctl0   <= '0;
			regctl1   <= '0;
			regctl2   <= '0;
			regctl3   <= '0;
			vdl_addr  <= '0;
			msb_check <= '0;
		end else if (cpu_wr) begin
			case (ofs)
				madam_pkg::REG_MCTL:      mctl      <= cpu_din;
				madam_pkg::REG_MSB_CHECK: msb_check <= cpu_din;
				madam_pkg::REG_REGCTL0:   regctl0   <= cpu_din;
				madam_pkg::REG_REGCTL1:   regctl1   <= cpu_din;
				madam_pkg::REG_REGCTL2:   regctl2   <= cpu_din;
				madam_pkg::REG_REGCTL3:   regctl3   <= cpu_din;
				madam_pkg::REG_VDL_ADDR:  vdl_addr  <= cpu_din;
				default: ;  // msysbits is read only, unmapped writes are dropped.
			endcase
		end
	end

	// priority search, the last set bit seen going upward wins.
	always_comb begin
		msb_idx = madam_pkg::NO_MSB;  // all ones when nothing is set.
		for (int i = 0; i < madam_pkg::DATA_W; i++) begin
			if (msb_check[i]) begin
				msb_idx = madam_pkg::DATA_W'(i);
			end
		end
	end

	// hcount in 27:16, flags in 6:0, rest reads zero.
	always_comb begin
		line_stat = '0;
		line_stat[madam_pkg::LSTAT_HCOUNT_LSB +: madam_pkg::HCOUNT_W] = hcount;
		line_stat[madam_pkg::LINE_FLAG_W-1:0] = flags;
	end

	// read data, combinational from the offset and register state.
	always_comb begin
		if (mtx_hit) begin
			cpu_dout = mtx_rdata;  // unused window words come back as zero.
		end else begin
			case (ofs)
				madam_pkg::REG_MSYSBITS:  cpu_dout = madam_pkg::MSYSBITS_VALUE;
				madam_pkg::REG_MCTL:      cpu_dout = mctl;
				madam_pkg::REG_MSB_CHECK: cpu_dout = msb_idx;
				madam_pkg::REG_LINE_STAT: cpu_dout = line_stat;
				madam_pkg::REG_REGCTL0:   cpu_dout = regctl0;
				madam_pkg::REG_REGCTL1:   cpu_dout = regctl1;
				madam_pkg::REG_REGCTL2:   cpu_dout = regctl2;
				madam_pkg::REG_REGCTL3:   cpu_dout = regctl3;
				madam_pkg::REG_VDL_ADDR:  cpu_dout = vdl_addr;
				madam_pkg::MTX_CMD:       cpu_dout = {31'd0, mtx_busy};  // busy in bit 0.
				default:                  cpu_dout = madam_pkg::BAD_ACCESS;
			endcase
		end
	end

endmodule

// ==== hdl/madam.sv ====
// madam cpu-facing top level.
// ties the cpu register bus and the pcsc serial line to the register file,
// the line-flag receiver and the matrix engine.

`timescale 1ns/1ps

module madam (
	input  logic        clk_25m,
	input  logic        reset_n,

	input  logic [31:0] cpu_addr,  // only the low 16 bits are decoded.
	input  logic [31:0] cpu_din,
	input  logic        cpu_wr,    // write strobe, one cycle per write.
	output logic [31:0] cpu_dout,  // combinational read data.

	input  logic        pcsc       // serial line start and flags from clio.
);

	logic [madam_pkg::LINE_FLAG_W-1:0] flags;
	logic [madam_pkg::HCOUNT_W-1:0]    hcount;

	// register file to matrix engine.
	logic                            mtx_wr;
	logic [madam_pkg::MTX_IDX_W-1:0] mtx_idx;
	logic [madam_pkg::DATA_W-1:0]    mtx_wdata;
	logic                            mtx_cmd_wr;
	madam_pkg::mtx_cmd_e             mtx_cmd;
	logic [madam_pkg::DATA_W-1:0]    mtx_rdata;
	logic                            mtx_busy;

	line_flags line_flags_inst (
		.clk_25m (clk_25m),
		.reset_n (reset_n),
		.pcsc    (pcsc),
		.flags   (flags),
		.hcount  (hcount)
	);

	matrix_engine matrix_engine_inst (
		.clk_25m    (clk_25m),
		.reset_n    (reset_n),
		.mtx_wr     (mtx_wr),
		.mtx_idx    (mtx_idx),
		.mtx_wdata  (mtx_wdata),
		.mtx_cmd_wr (mtx_cmd_wr),
		.mtx_cmd    (mtx_cmd),
		.mtx_rdata  (mtx_rdata),
		.mtx_busy   (mtx_busy)
	);

	madam_regs madam_regs_inst (
		.clk_25m    (clk_25m),
		.reset_n    (reset_n),
		.cpu_addr   (cpu_addr),
		.cpu_din    (cpu_din),
		.cpu_wr     (cpu_wr),
		.cpu_dout   (cpu_dout),
		.flags      (flags),
		.hcount     (hcount),
		.mtx_wr     (mtx_wr),
		.mtx_idx    (mtx_idx),
		.mtx_wdata  (mtx_wdata),
		.mtx_cmd_wr (mtx_cmd_wr),
		.mtx_cmd    (mtx_cmd),
		.mtx_rdata  (mtx_rdata),
		.mtx_busy   (mtx_busy)
	);

endmodule

// ==== testbench/madam_asserts.sv ====
// concurrent checks on the matrix engine, bound into every instance of it.

`timescale 1ns/1ps

module madam_asserts (
	input logic         clk_25m,
	input logic         reset_n,
	input logic         mtx_cmd_wr,
	input logic         mtx_busy,
	input logic [127:0] rez_all  // visible results, 3 down to 0.
);

	logic [4:0] busy_run;  // length of the current busy stretch.

	always_ff @(posedge clk_25m or negedge reset_n) begin
		if (!reset_n)
			busy_run <= '0;
		else
			busy_run <= mtx_busy ? busy_run + 5'd1 : 5'd0;
	end

	a_reset_idle: assert property (@(posedge clk_25m) !reset_n |-> !mtx_busy)
		else $error("matrix engine busy during reset");

	a_busy_len: assert property (@(posedge clk_25m) disable iff (!reset_n) busy_run <= 5'd16)
		else $error("matrix engine busy for more than 16 cycles");

	a_rez_hold: assert property (@(posedge clk_25m) disable iff (!reset_n)
		$changed(rez_all) |-> $past(mtx_cmd_wr && !mtx_busy))
		else $error("visible results changed without an accepted command");

endmodule

bind matrix_engine madam_asserts asserts_inst (
	.clk_25m    (clk_25m),
	.reset_n    (reset_n),
	.mtx_cmd_wr (mtx_cmd_wr),
	.mtx_busy   (mtx_busy),
	.rez_all    ({rez[3], rez[2], rez[1], rez[0]})
);

// ==== testbench/madam_check.sv ====
// checker for the madam testbench.
// keeps a model of the registers, matrix engine and line flags from the bus
// and pcsc, and compares cpu_dout on every sample strobe.

`timescale 1ns/1ps

module madam_check (
	input  logic        clk_25m,
	input  logic        reset_n,
	input  logic [31:0] cpu_addr,
	input  logic [31:0] cpu_din,
	input  logic        cpu_wr,
	input  logic [31:0] cpu_dout,
	input  logic        pcsc,
	input  logic        sample,
	input  logic        test_end,
	input  logic [7:0]  test_num,
	output int          checks,
	output int          errors
);

	logic [31:0] mctl_m, vdl_m, msb_m;
	logic [31:0] ctl_m  [4];
	logic [31:0] m_m    [16];
	logic [31:0] v_m    [4];
	logic [31:0] rez_m  [4];
	logic [31:0] pend_m [4];
	int          busy_left;  // cycles of the run still to go.
	logic        pq, pqq;    // pcsc samples.
	logic [2:0]  bit_m;
	logic [5:0]  stage_m;
	logic [6:0]  flags_m;
	logic [11:0] hc_m;
	logic        ph_m;
	int          test_errs;
	logic [15:0] wofs;

	assign wofs = cpu_addr[15:0];

	// sum of signed products over n columns, back to 16.16, low 32 bits.
	function automatic logic [31:0] row_result(input int r, input int n);
		logic signed [63:0] sum;
		sum = '0;
		for (int c = 0; c < n; c++)
			sum = sum + ($signed(m_m[r * 4 + c]) * $signed(v_m[c]));
		return 32'(sum >>> 16);
	endfunction

	function automatic logic [31:0] highest_bit(input logic [31:0] x);
		logic found;
		logic [31:0] r;
		found = 1'b0;
		r = '1;
		for (int i = 31; i >= 0; i--) begin
			if (x[i] && !found) begin
				found = 1'b1;
				r = 32'(i);
			end
		end
		return r;
	endfunction

	// expected read data for an offset.
	function automatic logic [31:0] expect_read(input logic [15:0] ofs);
		logic [4:0] idx;
		idx = ofs[6:2];
		if ((ofs >= 16'h0600) && (ofs < 16'h0680) && (ofs[1:0] == 2'b00)) begin
			if (idx < 16) return m_m[idx];
			if (idx < 20) return v_m[idx - 16];
			if ((idx >= 24) && (idx < 28)) return rez_m[idx - 24];
			return '0;  // gaps in the window.
		end
		case (ofs)
			16'h0004: return 32'h29;
			16'h0008: return mctl_m;
			16'h002C: return highest_bit(msb_m);
			16'h0030: return {4'd0, hc_m, 9'd0, flags_m};
			16'h0130: return ctl_m[0];
			16'h0134: return ctl_m[1];
			16'h0138: return ctl_m[2];
			16'h013C: return ctl_m[3];
			16'h0580: return vdl_m;
			16'h07FC: return {31'd0, busy_left != 0};
			default:  return 32'hBADACCE5;
		endcase
	endfunction

	always @(posedge clk_25m or negedge reset_n) begin
		if (!reset_n) begin
			mctl_m <= '0;
			vdl_m <= '0;
			msb_m <= '0;
			for (int i = 0; i < 16; i++)
				m_m[i] <= '0;
			for (int i = 0; i < 4; i++) begin
				ctl_m[i] <= '0;
				v_m[i] <= '0;
				rez_m[i] <= '0;
				pend_m[i] <= '0;
			end
			busy_left <= 0;
			pq <= 1'b0;
			pqq <= 1'b0;
			bit_m <= '0;
			stage_m <= '0;
			flags_m <= '0;
			hc_m <= '0;
			ph_m <= 1'b0;
		end else begin
			if (cpu_wr) begin
				case (wofs)
					16'h0008: mctl_m <= cpu_din;
					16'h002C: msb_m <= cpu_din;
					16'h0130: ctl_m[0] <= cpu_din;
					16'h0134: ctl_m[1] <= cpu_din;
					16'h0138: ctl_m[2] <= cpu_din;
					16'h013C: ctl_m[3] <= cpu_din;
					16'h0580: vdl_m <= cpu_din;
					default: ;
				endcase
				if ((busy_left == 0) && (wofs >= 16'h0600) && (wofs < 16'h0650) &&
					(wofs[1:0] == 2'b00)) begin
					if (wofs < 16'h0640)
						m_m[wofs[5:2]] <= cpu_din;
					else
						v_m[wofs[3:2]] <= cpu_din;
				end
			end
			// accepted command publishes pending results and starts a run.
			if (cpu_wr && (wofs == 16'h07FC) && (busy_left == 0)) begin
				rez_m <= pend_m;
				if (cpu_din[1:0] == 2'd1) begin
					for (int r = 0; r < 4; r++)
						pend_m[r] <= row_result(r, 4);
					busy_left <= 16;
				end else if (cpu_din[1:0] == 2'd2) begin
					for (int r = 0; r < 3; r++)
						pend_m[r] <= row_result(r, 3);
					busy_left <= 9;
				end
			end else if (busy_left != 0) begin
				busy_left <= busy_left - 1;
			end
			// line start seen one edge late, only when idle.
			pq <= pcsc;
			pqq <= pq;
			if (pq && !pqq && (bit_m == 3'd0)) begin
				bit_m <= 3'd1;
				hc_m <= '0;
				ph_m <= 1'b0;
			end else begin
				ph_m <= !ph_m;
				if (ph_m)
					hc_m <= hc_m + 12'd1;
			end
			if (bit_m != 3'd0) begin
				bit_m <= bit_m + 3'd1;
				if (bit_m == 3'd7)
					flags_m <= {pq, stage_m};
				else
					stage_m[bit_m - 3'd1] <= pq;
			end
		end
	end

	initial begin
		checks = 0;
		errors = 0;
		test_errs = 0;
	end

	always @(negedge clk_25m) begin
		logic [31:0] exp_val;
		if (sample) begin
			exp_val = expect_read(wofs);
			checks++;
			if (cpu_dout !== exp_val) begin
				errors++;
				test_errs++;
				$display("mismatch cpu_dout at offset %h: got %h expected %h",
					wofs, cpu_dout, exp_val);
			end
		end
		if (test_end) begin
			$display("test %0d done, %0d errors", test_num, test_errs);
			test_errs = 0;
		end
	end

endmodule

// ==== testbench/madam_tb.sv ====
// testbench top for the madam block.
// generates clock and reset, drives the cpu bus and pcsc, and runs the tests.
// the checker module compares every read against its own model.

`timescale 1ns/1ps

module madam_tb;

	logic        clk_25m;
	logic        reset_n;
	logic [31:0] cpu_addr;
	logic [31:0] cpu_din;
	logic        cpu_wr;
	logic [31:0] cpu_dout;
	logic        pcsc;

	logic        sample;    // tells the checker to compare this cycle.
	logic        test_end;  // one-cycle pulse when a test finishes.
	logic [7:0]  test_num;
	int          checks;
	int          errors;
	int          timeouts;
	integer      seed;

	madam madam_inst (
		.clk_25m  (clk_25m),
		.reset_n  (reset_n),
		.cpu_addr (cpu_addr),
		.cpu_din  (cpu_din),
		.cpu_wr   (cpu_wr),
		.cpu_dout (cpu_dout),
		.pcsc     (pcsc)
	);

	madam_check check_inst (
		.clk_25m  (clk_25m),
		.reset_n  (reset_n),
		.cpu_addr (cpu_addr),
		.cpu_din  (cpu_din),
		.cpu_wr   (cpu_wr),
		.cpu_dout (cpu_dout),
		.pcsc     (pcsc),
		.sample   (sample),
		.test_end (test_end),
		.test_num (test_num),
		.checks   (checks),
		.errors   (errors)
	);

	// 40 ns period.
	initial begin
		clk_25m = 1'b0;
		forever #20 clk_25m = !clk_25m;
	end

	// moves to 2 ns past the next rising edge.
	task automatic step();
		@(posedge clk_25m);
		#2;
	endtask

	task automatic write_reg(input logic [15:0] ofs, input logic [31:0] data);
		cpu_addr = {16'h0000, ofs};
		cpu_din  = data;
		cpu_wr   = 1'b1;
		step();
		cpu_wr   = 1'b0;
	endtask

	// reads with a compare strobe and takes the value at the falling edge.
	task automatic read_reg(input logic [15:0] ofs, output logic [31:0] data);
		cpu_addr = {16'h0000, ofs};
		cpu_wr   = 1'b0;
		sample   = 1'b1;
		@(negedge clk_25m);
		data = cpu_dout;
		step();
		sample   = 1'b0;
	endtask

	task automatic finish_test(input logic [7:0] num);
		test_num = num;
		test_end = 1'b1;
		step();
		test_end = 1'b0;
	endtask

	// polls the busy bit of the command word and gives up after 40 polls.
	task automatic wait_idle();
		logic [31:0] st;
		int          n;
		st = 32'd1;
		n  = 0;
		while (st[0] && (n < 40)) begin
			read_reg(16'h07FC, st);
			n++;
		end
		if (st[0]) begin
			$display("timeout: matrix engine still busy after %0d polls", n);
			timeouts++;
		end
	endtask

	function automatic logic [15:0] unmapped_ofs();
		return 16'h2000 | (16'($random(seed)) & 16'h0FFC);  // nothing lives at 0x2000.
	endfunction

	task automatic load_matrix();
		for (int i = 0; i < 20; i++)
			write_reg(16'h0600 + 16'(i * 4), $random(seed));
	endtask

	task automatic send_line(input logic [6:0] bits);
		pcsc = 1'b0;
		repeat (3) step();
		pcsc = 1'b1;  // line start.
		step();
		for (int b = 0; b < 7; b++) begin
			pcsc = bits[b];
			step();
		end
		pcsc = 1'b0;
		repeat (3) step();
	endtask

	initial begin
		logic [31:0] rd;
		logic [15:0] plain [6];
		seed     = 32'hf8527c39;
		timeouts = 0;
		cpu_addr = '0;
		cpu_din  = '0;
		cpu_wr   = 1'b0;
		pcsc     = 1'b0;
		sample   = 1'b0;
		test_end = 1'b0;
		test_num = '0;
		reset_n  = 1'b0;
		plain    = '{16'h0008, 16'h0130, 16'h0134, 16'h0138, 16'h013C, 16'h0580};
		repeat (10) @(posedge clk_25m);
		#2 reset_n = 1'b1;
		step();

		// 1. values after reset.
		read_reg(16'h0004, rd);
		read_reg(16'h0030, rd);
		read_reg(unmapped_ofs(), rd);
		finish_test(8'd1);

		// 2. plain registers read back and unmapped writes go nowhere.
		foreach (plain[i]) begin
			write_reg(plain[i], $random(seed));
			read_reg(plain[i], rd);
		end
		write_reg(unmapped_ofs(), $random(seed));
		write_reg(16'h0004, $random(seed));  // read only.
		foreach (plain[i])
			read_reg(plain[i], rd);
		read_reg(16'h0004, rd);
		finish_test(8'd2);

		// 3. msb finder.
		for (int i = 0; i < 10; i++) begin
			write_reg(16'h002C, $random(seed));
			read_reg(16'h002C, rd);
		end
		for (int b = 0; b < 32; b++) begin
			write_reg(16'h002C, 32'd1 << b);
			read_reg(16'h002C, rd);
		end
		write_reg(16'h002C, 32'd0);
		read_reg(16'h002C, rd);
		finish_test(8'd3);

		// 4. 4x4 multiply whose results show up only after the next command.
		load_matrix();
		write_reg(16'h07FC, 32'd1);
		wait_idle();
		for (int r = 0; r < 4; r++)
			read_reg(16'h0660 + 16'(r * 4), rd);  // run is done but still unpublished.
		write_reg(16'h07FC, 32'd0);
		for (int r = 0; r < 4; r++)
			read_reg(16'h0660 + 16'(r * 4), rd);
		finish_test(8'd4);

		// 5. 3x3 multiply with a command and a matrix write while busy.
		load_matrix();
		write_reg(16'h07FC, 32'd2);
		write_reg(16'h07FC, 32'd1);          // ignored.
		write_reg(16'h0600, $random(seed));  // ignored.
		read_reg(16'h07FC, rd);
		wait_idle();
		write_reg(16'h07FC, 32'd0);
		for (int r = 0; r < 4; r++)
			read_reg(16'h0660 + 16'(r * 4), rd);
		read_reg(16'h0600, rd);
		finish_test(8'd5);

		// 6. line flags over pcsc where the first pattern toggles on every bit.
		send_line(7'b1010101);
		read_reg(16'h0030, rd);
		for (int i = 0; i < 7; i++) begin
			send_line(7'($random(seed)));
			read_reg(16'h0030, rd);
		end
		finish_test(8'd6);

		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if ((errors == 0) && (timeouts == 0)) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== madam.f ====
common/madam_pkg.sv
hdl/line_flags.sv
matrix/matrix_engine.sv
hdl/madam_regs.sv
hdl/madam.sv
testbench/madam_asserts.sv
testbench/madam_check.sv
testbench/madam_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the madam testbench with verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f madam.f --top-module madam_tb -o Vmadam_tb \
	&& ./obj_dir/Vmadam_tb | tee /dev/stderr | grep -q "Simulation completed successfully" \
	&& echo "run passed" \
	|| { echo "run failed"; exit 1; }
